//--- src/rob_pkg.sv
package rob_pkg;

	// Register file sizes
	localparam int ARCH_REGS = 32;
	localparam int ARCH_BITS = 5;
	localparam int PHYS_REGS = 64;
	localparam int PHYS_BITS = 6;

	// Reorder buffer depth
	localparam int ROB_SIZE = 16;
	localparam int ROB_BITS = 4;

	typedef logic [PHYS_BITS-1:0] phys_tag_t;
	typedef logic [ARCH_BITS-1:0] arch_idx_t;

	// One row of the reorder buffer
	typedef struct packed {
		logic      busy;      // Row holds a live instruction
		logic      ready;     // Result was broadcast on the CDB
		arch_idx_t arch_dest;
		phys_tag_t t_new;     // Tag written by this instruction
		phys_tag_t t_old;     // Tag it replaces, freed at retire
	} rob_entry_t;

	// Record handed from rename to the reorder buffer
	typedef struct packed {
		arch_idx_t arch_dest;
		phys_tag_t t_new;
		phys_tag_t t_old;
	} dispatch_t;

	// Common data bus broadcast
	typedef struct packed {
		logic      valid;
		phys_tag_t tag;
	} cdb_t;

	// Head of the reorder buffer leaving in program order
	typedef struct packed {
		logic      valid;
		arch_idx_t arch_dest;
		phys_tag_t t_new;
		phys_tag_t t_old;
	} retire_t;

endpackage

//--- src/rob_cam.sv
`timescale 1ns/1ps

module rob_cam (
	input  logic [rob_pkg::ROB_SIZE-1:0]                  busy_vec,
	input  rob_pkg::phys_tag_t [rob_pkg::ROB_SIZE-1:0]    entry_tags,
	input  rob_pkg::cdb_t                                 cdb,
	output logic [rob_pkg::ROB_SIZE-1:0]                  hit
);

	import rob_pkg::*;

	// One comparator per row, qualified by row busy and bus valid
	always_comb begin
		hit = '0;
		for (int i = 0; i < ROB_SIZE; i++) begin
			hit[i] = cdb.valid && busy_vec[i] && (entry_tags[i] == cdb.tag);
		end
	end

endmodule

//--- src/rob.sv
`timescale 1ns/1ps

module rob (
	input  logic                         clock,
	input  logic                         rst,
	input  logic                         flush,
	input  logic                         dispatch_en,
	input  rob_pkg::dispatch_t           dispatch_in,
	input  rob_pkg::cdb_t                cdb,
	output rob_pkg::retire_t             retire_out,
	output logic                         rob_full,
	output logic [rob_pkg::ROB_BITS:0]   rob_free_entries
);

	import rob_pkg::*;

	rob_entry_t [ROB_SIZE-1:0] entries;
	logic [ROB_BITS-1:0]       head;
	logic [ROB_BITS-1:0]       tail;
	logic [ROB_BITS:0]         count;    // Live rows from 0 to ROB_SIZE

	logic [ROB_SIZE-1:0]       busy_vec;
	phys_tag_t [ROB_SIZE-1:0]  entry_tags;
	logic [ROB_SIZE-1:0]       cam_hit;
	logic                      retire_fire;
	rob_entry_t                head_entry;

	// Flatten rows for the CAM
	always_comb begin
		for (int i = 0; i < ROB_SIZE; i++) begin
			busy_vec[i]   = entries[i].busy;
			entry_tags[i] = entries[i].t_new;
		end
	end

	rob_cam u_cam (
		.busy_vec   (busy_vec),
		.entry_tags (entry_tags),
		.cdb        (cdb),
		.hit        (cam_hit)
	);

	assign head_entry  = entries[head];
	assign retire_fire = head_entry.busy && head_entry.ready;

	always_comb begin
		retire_out.valid     = retire_fire;
		retire_out.arch_dest = head_entry.arch_dest;
		retire_out.t_new     = head_entry.t_new;
		retire_out.t_old     = head_entry.t_old;
	end

	assign rob_full         = (count == (ROB_BITS+1)'(ROB_SIZE));
	assign rob_free_entries = (ROB_BITS+1)'(ROB_SIZE) - count;

	always_ff @(posedge clock) begin
		if (rst || flush) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			for (int i = 0; i < ROB_SIZE; i++) begin
				entries[i].busy  <= 1'b0;
				entries[i].ready <= 1'b0;
			end
		end else begin
			// Completion marks every matching row
			for (int i = 0; i < ROB_SIZE; i++) begin
				if (cam_hit[i]) begin
					entries[i].ready <= 1'b1;
				end
			end

			if (retire_fire) begin
				entries[head].busy  <= 1'b0;
				entries[head].ready <= 1'b0;
				head                <= head + 1'b1;    // Wraps at ROB_SIZE
			end

			// Tail never equals a retiring head because full blocks dispatch
			if (dispatch_en) begin
				entries[tail].busy      <= 1'b1;
				entries[tail].ready     <= 1'b0;
				entries[tail].arch_dest <= dispatch_in.arch_dest;
				entries[tail].t_new     <= dispatch_in.t_new;
				entries[tail].t_old     <= dispatch_in.t_old;
				tail                    <= tail + 1'b1;
			end

			case ({dispatch_en, retire_fire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- src/rename_stage.sv
`timescale 1ns/1ps

module rename_stage (
	input  logic                                        clock,
	input  logic                                        rst,
	input  logic                                        flush,
	input  logic                                        dispatch_valid,
	input  rob_pkg::arch_idx_t                          dispatch_arch,
	input  logic                                        rob_full,
	input  logic                                        free_valid,
	input  rob_pkg::phys_tag_t                          free_tag,
	input  rob_pkg::phys_tag_t [rob_pkg::ARCH_REGS-1:0] arch_map,
	output logic                                        dispatch_ready,
	output logic                                        dispatch_en,
	output rob_pkg::dispatch_t                          dispatch_out
);

	import rob_pkg::*;

	phys_tag_t [ARCH_REGS-1:0] map_table;    // Speculative map
	logic [PHYS_REGS-1:0]      free_bits;    // One bit per physical tag

	phys_tag_t                 new_tag;
	logic                      any_free;
	logic [PHYS_REGS-1:0]      arch_named;   // Tags held by the architectural map

	// Lowest free tag wins, so scan from the top down
	always_comb begin
		new_tag = '0;
		for (int i = PHYS_REGS - 1; i >= 0; i--) begin
			if (free_bits[i]) begin
				new_tag = PHYS_BITS'(i);
			end
		end
	end

	assign any_free = |free_bits;

	always_comb begin
		arch_named = '0;
		for (int i = 0; i < ARCH_REGS; i++) begin
			arch_named[arch_map[i]] = 1'b1;
		end
	end

	assign dispatch_ready = !rob_full && any_free;
	assign dispatch_en    = dispatch_valid && dispatch_ready;

	always_comb begin
		dispatch_out.arch_dest = dispatch_arch;
		dispatch_out.t_new     = new_tag;
		dispatch_out.t_old     = map_table[dispatch_arch];
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < ARCH_REGS; i++) begin
				map_table[i] <= PHYS_BITS'(i);    // Identity mapping
			end
			for (int i = 0; i < PHYS_REGS; i++) begin
				free_bits[i] <= (i >= ARCH_REGS);
			end
		end else if (flush) begin
			// Recover from the committed state
			map_table <= arch_map;
			free_bits <= ~arch_named;
		end else begin
			if (free_valid) begin
				free_bits[free_tag] <= 1'b1;
			end
			// A returning tag was busy, so it never matches new_tag
			if (dispatch_en) begin
				map_table[dispatch_arch] <= new_tag;
				free_bits[new_tag]       <= 1'b0;
			end
		end
	end

endmodule

//--- src/retire_stage.sv
`timescale 1ns/1ps

module retire_stage (
	input  logic                                        clock,
	input  logic                                        rst,
	input  logic                                        flush,
	input  rob_pkg::retire_t                            retire_in,
	output logic                                        free_valid,
	output rob_pkg::phys_tag_t                          free_tag,
	output rob_pkg::phys_tag_t [rob_pkg::ARCH_REGS-1:0] arch_map
);

	import rob_pkg::*;

	logic commit;

	// Flush wins over a retire in the same cycle
	assign commit = retire_in.valid && !flush;

	always_ff @(posedge clock) begin
		if (rst) begin
			free_valid <= 1'b0;
			for (int i = 0; i < ARCH_REGS; i++) begin
				arch_map[i] <= PHYS_BITS'(i);    // Same as the speculative map
			end
		end else begin
			free_valid <= commit;    // One-cycle return pulse
			if (commit) begin
				arch_map[retire_in.arch_dest] <= retire_in.t_new;
			end
		end
	end

	// Replaced tag that travels with the return pulse
	always_ff @(posedge clock) begin
		free_tag <= retire_in.t_old;
	end

endmodule

//--- src/rename_rob_top.sv
`timescale 1ns/1ps

module rename_rob_top (
	input  logic                         clock,
	input  logic                         rst,
	input  logic                         flush,
	input  logic                         dispatch_valid,
	input  rob_pkg::arch_idx_t           dispatch_arch,
	input  rob_pkg::cdb_t                cdb,
	output logic                         dispatch_ready,
	output rob_pkg::dispatch_t           dispatch_out,
	output rob_pkg::retire_t             retire_out,
	output logic                         rob_full,
	output logic [rob_pkg::ROB_BITS:0]   rob_free_entries
);

	import rob_pkg::*;

	logic                      dispatch_en;
	logic                      free_valid;
	phys_tag_t                 free_tag;
	phys_tag_t [ARCH_REGS-1:0] arch_map;

	rename_stage u_rename (
		.clock          (clock),
		.rst            (rst),
		.flush          (flush),
		.dispatch_valid (dispatch_valid),
		.dispatch_arch  (dispatch_arch),
		.rob_full       (rob_full),
		.free_valid     (free_valid),
		.free_tag       (free_tag),
		.arch_map       (arch_map),
		.dispatch_ready (dispatch_ready),
		.dispatch_en    (dispatch_en),
		.dispatch_out   (dispatch_out)
	);

	rob u_rob (
		.clock            (clock),
		.rst              (rst),
		.flush            (flush),
		.dispatch_en      (dispatch_en),
		.dispatch_in      (dispatch_out),
		.cdb              (cdb),
		.retire_out       (retire_out),
		.rob_full         (rob_full),
		.rob_free_entries (rob_free_entries)
	);

	// Returns old tags to the free list and feeds flush recovery
	retire_stage u_retire (
		.clock      (clock),
		.rst        (rst),
		.flush      (flush),
		.retire_in  (retire_out),
		.free_valid (free_valid),
		.free_tag   (free_tag),
		.arch_map   (arch_map)
	);

endmodule

//--- tb/rename_rob_tb.sv
`timescale 1ns/1ps

module rename_rob_tb;

	import rob_pkg::*;

	// A model entry is a dispatch record plus its completion state
	typedef struct packed {
		logic      done;
		dispatch_t rec;
	} pend_t;

	logic                clock;
	logic                rst;
	logic                flush;
	logic                dispatch_valid;
	arch_idx_t           dispatch_arch;
	cdb_t                cdb;
	logic                dispatch_ready;
	dispatch_t           dispatch_out;
	retire_t             retire_out;
	logic                rob_full;
	logic [ROB_BITS:0]   rob_free_entries;

	// Reference model state
	phys_tag_t            spec_map [ARCH_REGS];
	phys_tag_t            arch_model [ARCH_REGS];
	logic [PHYS_REGS-1:0] free_set;
	logic                 ret_pending;    // Tag return on its way to the free list
	phys_tag_t            ret_tag;
	pend_t                rob_q [$];

	// Expected outputs for the current cycle
	logic [ROB_BITS:0]    exp_free_entries;
	logic                 exp_full;
	logic                 exp_ready;
	phys_tag_t            exp_t_new;
	phys_tag_t            exp_t_old;
	retire_t              exp_ret;

	int value_errors = 0;
	int state_errors = 0;
	int reset_cycles = 16;
	int rand_cycles  = 600;

	rename_rob_top UUT (
		.clock            (clock),
		.rst              (rst),
		.flush            (flush),
		.dispatch_valid   (dispatch_valid),
		.dispatch_arch    (dispatch_arch),
		.cdb              (cdb),
		.dispatch_ready   (dispatch_ready),
		.dispatch_out     (dispatch_out),
		.retire_out       (retire_out),
		.rob_full         (rob_full),
		.rob_free_entries (rob_free_entries)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic void report_value(input string sig, input int unsigned exp_val,
			input int unsigned act_val);
		value_errors++;
		$display("ERR %0t %s expected 'h%0h actual 'h%0h", $time, sig, exp_val, act_val);
	endfunction

	function automatic void report_state(input string what);
		state_errors++;
		$display("At %0t: %s", $time, what);
	endfunction

	function automatic phys_tag_t lowest_free(input logic [PHYS_REGS-1:0] set);
		for (int i = 0; i < PHYS_REGS; i++) begin
			if (set[i]) return PHYS_BITS'(i);
		end
		return '0;
	endfunction

	function automatic void reset_model();
		for (int i = 0; i < ARCH_REGS; i++) begin
			spec_map[i]   = PHYS_BITS'(i);
			arch_model[i] = PHYS_BITS'(i);
		end
		for (int i = 0; i < PHYS_REGS; i++) begin
			free_set[i] = (i >= ARCH_REGS);
		end
		ret_pending = 1'b0;
		ret_tag     = '0;
		rob_q.delete();
	endfunction

	// Expected port values from model state and the inputs now driven
	function automatic void refresh_expect();
		exp_free_entries = (ROB_BITS+1)'(ROB_SIZE - rob_q.size());
		exp_full         = (rob_q.size() == ROB_SIZE);
		exp_ready        = !exp_full && (free_set != '0);
		exp_t_new        = lowest_free(free_set);
		exp_t_old        = spec_map[dispatch_arch];
		exp_ret          = '0;
		if (rob_q.size() > 0 && rob_q[0].done) begin
			exp_ret.valid     = 1'b1;
			exp_ret.arch_dest = rob_q[0].rec.arch_dest;
			exp_ret.t_new     = rob_q[0].rec.t_new;
			exp_ret.t_old     = rob_q[0].rec.t_old;
		end
	endfunction

	// What the clock edge does, judged from the inputs of the cycle before it
	function automatic void update_model();
		pend_t   entry;
		retire_t retired;
		if (flush) begin
			rob_q.delete();
			spec_map = arch_model;
			free_set = '1;
			for (int i = 0; i < ARCH_REGS; i++) begin
				free_set[arch_model[i]] = 1'b0;
			end
			ret_pending = 1'b0;    // Returned tag is free after the rebuild anyway
		end else begin
			retired = exp_ret;
			if (ret_pending) free_set[ret_tag] = 1'b1;
			ret_pending = 1'b0;
			if (cdb.valid) begin
				foreach (rob_q[i]) begin
					if (rob_q[i].rec.t_new == cdb.tag) rob_q[i].done = 1'b1;
				end
			end
			if (retired.valid) begin
				void'(rob_q.pop_front());
				arch_model[retired.arch_dest] = retired.t_new;
				ret_pending = 1'b1;
				ret_tag     = retired.t_old;
			end
			if (dispatch_valid && exp_ready) begin
				entry.done          = 1'b0;
				entry.rec.arch_dest = dispatch_arch;
				entry.rec.t_new     = exp_t_new;
				entry.rec.t_old     = exp_t_old;
				rob_q.push_back(entry);
				spec_map[dispatch_arch] = exp_t_new;
				free_set[exp_t_new]     = 1'b0;
			end
		end
	endfunction

	task automatic next_cycle(input logic f, input logic dv, input arch_idx_t da,
			input cdb_t c);
		@(posedge clock);
		update_model();
		#1;
		flush          = f;
		dispatch_valid = dv;
		dispatch_arch  = da;
		cdb            = c;
		refresh_expect();
	endtask

	// Oldest outstanding entry that has not been broadcast yet
	function automatic cdb_t oldest_open_tag();
		cdb_t c;
		c = '0;
		foreach (rob_q[i]) begin
			if (!rob_q[i].done && !c.valid) begin
				c.valid = 1'b1;
				c.tag   = rob_q[i].rec.t_new;
			end
		end
		return c;
	endfunction

	// Broadcast that completes the model entry at the given queue position
	function automatic cdb_t entry_broadcast(input int idx);
		cdb_t c;
		c       = '0;
		c.valid = 1'b1;
		c.tag   = rob_q[idx].rec.t_new;
		return c;
	endfunction

	task automatic random_cycle();
		logic      f;
		logic      dv;
		arch_idx_t da;
		cdb_t      c;
		int        r;
		f  = ($urandom % 64) == 0;
		dv = ($urandom % 4) != 0;
		da = arch_idx_t'($urandom);
		c  = '0;
		r  = $urandom % 8;
		if (r < 5 && rob_q.size() > 0) begin
			c.valid = 1'b1;    // Mostly hit a live entry
			c.tag   = rob_q[$urandom % rob_q.size()].rec.t_new;
		end else if (r == 5) begin
			c.valid = 1'b1;
			c.tag   = phys_tag_t'($urandom);
		end
		next_cycle(f, dv, da, c);
	endtask

	reset_state_check: assert property (@(posedge clock) $fell(rst) |->
			(rob_free_entries == ROB_SIZE && !rob_full && dispatch_ready && !retire_out.valid))
		else report_state("DUT status right after reset is wrong");

	free_count_check: assert property (@(posedge clock) disable iff (rst)
			rob_free_entries == exp_free_entries)
		else report_value("rob_free_entries", $sampled(exp_free_entries),
			$sampled(rob_free_entries));

	full_check: assert property (@(posedge clock) disable iff (rst) rob_full == exp_full)
		else report_value("rob_full", $sampled(exp_full), $sampled(rob_full));

	ready_check: assert property (@(posedge clock) disable iff (rst)
			dispatch_ready == exp_ready)
		else report_value("dispatch_ready", $sampled(exp_ready), $sampled(dispatch_ready));

	dest_check: assert property (@(posedge clock) disable iff (rst)
			(dispatch_valid && exp_ready) |-> dispatch_out.arch_dest == dispatch_arch)
		else report_value("dispatch_out.arch_dest", $sampled(dispatch_arch),
			$sampled(dispatch_out.arch_dest));

	new_tag_check: assert property (@(posedge clock) disable iff (rst)
			(dispatch_valid && exp_ready) |-> dispatch_out.t_new == exp_t_new)
		else report_value("dispatch_out.t_new", $sampled(exp_t_new),
			$sampled(dispatch_out.t_new));

	old_tag_check: assert property (@(posedge clock) disable iff (rst)
			(dispatch_valid && exp_ready) |-> dispatch_out.t_old == exp_t_old)
		else report_value("dispatch_out.t_old", $sampled(exp_t_old),
			$sampled(dispatch_out.t_old));

	retire_valid_check: assert property (@(posedge clock) disable iff (rst)
			retire_out.valid == exp_ret.valid)
		else report_value("retire_out.valid", $sampled(exp_ret.valid),
			$sampled(retire_out.valid));

	retire_record_check: assert property (@(posedge clock) disable iff (rst)
			exp_ret.valid |-> retire_out == exp_ret)
		else report_value("retire_out", $sampled(exp_ret), $sampled(retire_out));

	flush_empty_check: assert property (@(posedge clock) disable iff (rst)
			flush |=> rob_free_entries == ROB_SIZE)
		else report_value("rob_free_entries", ROB_SIZE, $sampled(rob_free_entries));

	initial begin
		int waits;
		void'($urandom(32'h3601_53f1));
		rst            = 1'b1;
		flush          = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_arch  = '0;
		cdb            = '0;
		reset_model();
		refresh_expect();
		repeat (reset_cycles) @(posedge clock);
		#1 rst = 1'b0;
		repeat (3) next_cycle(1'b0, 1'b0, '0, '0);

		// Fill the ROB with no completions, then keep pushing against back-pressure
		repeat (ROB_SIZE + 4) next_cycle(1'b0, 1'b1, arch_idx_t'($urandom), '0);
		next_cycle(1'b0, 1'b1, arch_idx_t'($urandom), oldest_open_tag());
		waits = 0;
		while (!dispatch_ready && waits < 10) begin
			next_cycle(1'b0, 1'b1, arch_idx_t'($urandom), '0);
			waits++;
		end
		if (!dispatch_ready) report_state("dispatch_ready stayed low after a retire");

		// Drain everything in order
		waits = 0;
		while (rob_q.size() > 0 && waits < 100) begin
			next_cycle(1'b0, 1'b0, '0, oldest_open_tag());
			waits++;
		end
		if (rob_q.size() > 0) report_state("ROB did not drain after all completions");

		// Flush with a retire and a tag return both in flight
		repeat (6) next_cycle(1'b0, 1'b1, arch_idx_t'($urandom), '0);
		next_cycle(1'b0, 1'b0, '0, entry_broadcast(0));
		next_cycle(1'b0, 1'b0, '0, entry_broadcast(1));
		next_cycle(1'b1, 1'b1, arch_idx_t'($urandom), oldest_open_tag());
		next_cycle(1'b0, 1'b1, arch_idx_t'($urandom), '0);
		repeat (3) next_cycle(1'b0, 1'b0, '0, '0);

		repeat (rand_cycles) random_cycle();
		repeat (4) next_cycle(1'b0, 1'b0, '0, '0);

		$display("Closing count: %0d value errors, %0d state errors",
			value_errors, state_errors);
		if (value_errors == 0 && state_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// Reset, directed phases, random phase and a margin
	initial begin
		int total_cycles;
		total_cycles = reset_cycles + 160 + rand_cycles + 200;
		#(total_cycles * 10);
		$display("Timeout: the run did not finish after %0d cycles", total_cycles);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- vlog.f
src/rob_pkg.sv
src/rob_cam.sv
src/rob.sv
src/rename_stage.sv
src/retire_stage.sv
src/rename_rob_top.sv
tb/rename_rob_tb.sv
